// ==== src/controlPkg.sv ====
// Control unit shared definitions
`default_nettype none

package controlPkg;

    // Primary opcodes
    typedef enum logic [5:0] {
        opRType = 6'b000000,
        opSram  = 6'b000001,
        opJ     = 6'b000010,
        opJal   = 6'b000011,
        opBeq   = 6'b000100,
        opBne   = 6'b000101,
        opBle   = 6'b000110,
        opBgt   = 6'b000111,
        opAddi  = 6'b001000,
        opAddiu = 6'b001001,
        opSlti  = 6'b001010,
        opLui   = 6'b001111,
        opLb    = 6'b100000,
        opLh    = 6'b100001,
        opLw    = 6'b100011,
        opSb    = 6'b101000,
        opSh    = 6'b101001,
        opRt    = 6'b101011
    } opcodeT;

    // R-type funct field
    typedef enum logic [5:0] {
        functSll   = 6'b000000,
        functSrl   = 6'b000010,
        functSra   = 6'b000011,
        functSllv  = 6'b000100,
        functDivm  = 6'b000101,
        functSrav  = 6'b000111,
        functJr    = 6'b001000,
        functBreak = 6'b001101,
        functMfhi  = 6'b010000,
        functMflo  = 6'b010010,
        functRte   = 6'b010011,
        functMult  = 6'b011000,
        functDiv   = 6'b011010,
        functAdd   = 6'b100000,
        functSub   = 6'b100010,
        functAnd   = 6'b100100,
        functSlt   = 6'b101010
    } functT;

    typedef enum logic [2:0] {
        classAdd,
        classSub,
        classAddi,
        classUnimpl,
        classInvalid
    } instrClassT;

    typedef enum logic [2:0] {
        stReset,
        stFetch,
        stDecode,
        stAluCompute,
        stAluWrite,
        stOverflow,
        stOpError,
        stUnimpl
    } stateT;

    typedef enum logic [2:0] {
        aluLoad = 3'b000,
        aluAdd  = 3'b001,
        aluSub  = 3'b010
    } aluOpT;

    localparam int StepWidth   = 2;
    localparam int FetchSteps  = 4;
    localparam int DecodeSteps = 2;

    // ALU A input
    localparam logic [1:0] srcAPc   = 2'b00;
    localparam logic [1:0] srcARegA = 2'b10;

    // ALU B input
    localparam logic [1:0] srcBRegB   = 2'b00;
    localparam logic [1:0] srcBFour   = 2'b01;
    localparam logic [1:0] srcBImm    = 2'b10;
    localparam logic [1:0] srcBBranch = 2'b11;

    // Register file write port
    localparam logic [1:0] wrRegRt     = 2'b00;
    localparam logic [1:0] wrRegRd     = 2'b01;
    localparam logic [1:0] wrRegStack  = 2'b11;
    localparam logic [2:0] wdAluOut    = 3'b000;
    localparam logic [2:0] wdStackInit = 3'b110;

endpackage

`default_nettype wire

// ==== src/opDecoder.sv ====
// Instruction class decoder
`timescale 1ns/1ps
`default_nettype none

module opDecoder (
    input  logic [5:0]             op,
    input  logic [5:0]             funct,
    output controlPkg::instrClassT instrClass
);
    import controlPkg::*;

    opcodeT opE;
    functT  functE;

    assign opE    = opcodeT'(op);
    assign functE = functT'(funct);

    always_comb begin
        instrClass = classInvalid;
        case (opE)
            opRType: begin
                case (functE)
                    functAdd: instrClass = classAdd;
                    functSub: instrClass = classSub;
                    functAnd, functDiv, functMult, functJr,
                    functMfhi, functMflo, functSll, functSllv,
                    functSlt, functSra, functSrav, functSrl,
                    functBreak, functRte, functDivm: begin
                        instrClass = classUnimpl;
                    end
                    // Unknown funct under R-type
                    default: instrClass = classInvalid;
                endcase
            end
            opAddi: instrClass = classAddi;
            // Recognized but not executed yet
            opAddiu, opBeq, opBne, opBle, opBgt,
            opSram, opLb, opLh, opLui, opLw,
            opSb, opSh, opSlti, opRt, opJ, opJal: begin
                instrClass = classUnimpl;
            end
            default: instrClass = classInvalid;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/controlSequencer.sv ====
// Control FSM state sequencer
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               overflow,
    input  controlPkg::instrClassT             instrClass,
    output controlPkg::stateT                  state,
    output logic [controlPkg::StepWidth-1:0]   step,
    output controlPkg::instrClassT             instrClassQ
);
    import controlPkg::*;

    stateT                stateNext;
    logic [StepWidth-1:0] stepNext;
    logic                 fetchDone;
    logic                 decodeDone;

    assign fetchDone  = (state == stFetch) && (step == StepWidth'(FetchSteps - 1));
    assign decodeDone = (state == stDecode) && (step == StepWidth'(DecodeSteps - 1));

    always_comb begin
        stateNext = state;
        stepNext  = '0;
        case (state)
            // Stack pointer init takes one cycle
            stReset: stateNext = stFetch;
            stFetch: begin
                if (fetchDone) begin
                    stateNext = stDecode;
                end else begin
                    stepNext = step + 1'b1;
                end
            end
            stDecode: begin
                if (decodeDone) begin
                    case (instrClass)
                        classAdd, classSub, classAddi: stateNext = stAluCompute;
                        classUnimpl:                   stateNext = stUnimpl;
                        default:                       stateNext = stOpError;
                    endcase
                end else begin
                    stepNext = step + 1'b1;
                end
            end
            // Overflow flag is valid at the end of compute
            stAluCompute: begin
                if (overflow) begin
                    stateNext = stOverflow;
                end else begin
                    stateNext = stAluWrite;
                end
            end
            stAluWrite, stOverflow, stOpError, stUnimpl: begin
                stateNext = stFetch;
            end
            default: stateNext = stReset;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stReset;
            step  <= '0;
        end else begin
            state <= stateNext;
            step  <= stepNext;
        end
    end

    // Class held for the execute states
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrClassQ <= classInvalid;
        end else if (decodeDone) begin
            instrClassQ <= instrClass;
        end
    end

endmodule

`default_nettype wire

// ==== src/controlEncoder.sv ====
// Datapath control output decode
`timescale 1ns/1ps
`default_nettype none

module controlEncoder (
    input  controlPkg::stateT                state,
    input  logic [controlPkg::StepWidth-1:0] step,
    input  controlPkg::instrClassT           instrClassQ,
    output logic                             pcWrite,
    output logic                             loadAB,
    output logic                             aluOutLoad,
    output logic                             memRead,
    output logic                             irWrite,
    output logic                             regWrite,
    output logic [1:0]                       aluSrcA,
    output logic [1:0]                       aluSrcB,
    output logic [1:0]                       wrReg,
    output logic [2:0]                       wdReg,
    output controlPkg::aluOpT                aluOp
);
    import controlPkg::*;

    logic isAddi;

    assign isAddi = (instrClassQ == classAddi);

    always_comb begin
        pcWrite    = 1'b0;
        loadAB     = 1'b0;
        aluOutLoad = 1'b0;
        memRead    = 1'b0;
        irWrite    = 1'b0;
        regWrite   = 1'b0;
        aluSrcA    = srcAPc;
        aluSrcB    = srcBRegB;
        wrReg      = wrRegRt;
        wdReg      = wdAluOut;
        aluOp      = aluLoad;
        case (state)
            stReset: begin
                regWrite = 1'b1;
                wrReg    = wrRegStack;
                wdReg    = wdStackInit;
            end
            stFetch: begin
                // PC + 4 computed while memory is read
                aluSrcA = srcAPc;
                aluSrcB = srcBFour;
                aluOp   = aluAdd;
                if (step == StepWidth'(FetchSteps - 1)) begin
                    pcWrite = 1'b1;
                    irWrite = 1'b1;
                end else begin
                    memRead = 1'b1;
                end
            end
            stDecode: begin
                if (step == '0) begin
                    // Speculative branch target
                    aluOutLoad = 1'b1;
                    aluSrcA    = srcAPc;
                    aluSrcB    = srcBBranch;
                    aluOp      = aluAdd;
                end else begin
                    loadAB = 1'b1;
                end
            end
            stAluCompute: begin
                aluOutLoad = 1'b1;
                aluSrcA    = srcARegA;
                aluSrcB    = isAddi ? srcBImm : srcBRegB;
                aluOp      = (instrClassQ == classSub) ? aluSub : aluAdd;
            end
            stAluWrite: begin
                regWrite = 1'b1;
                wrReg    = isAddi ? wrRegRt : wrRegRd;
                wdReg    = wdAluOut;
            end
            // Idle cycle before the next fetch
            default: begin
                aluOp = aluLoad;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/controlUnit.sv ====
// Multicycle control unit top
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic              clk,
    input  logic              arstN,
    input  logic              overflow,
    input  logic [5:0]        op,
    input  logic [5:0]        funct,
    output logic              pcWrite,
    output logic              loadAB,
    output logic              aluOutLoad,
    output logic              memRead,
    output logic              irWrite,
    output logic              regWrite,
    output logic [1:0]        aluSrcA,
    output logic [1:0]        aluSrcB,
    output logic [1:0]        wrReg,
    output logic [2:0]        wdReg,
    output controlPkg::aluOpT aluOp
);
    import controlPkg::*;

    instrClassT           instrClass;
    instrClassT           instrClassQ;
    stateT                state;
    logic [StepWidth-1:0] step;

    opDecoder u_decoder (
        .op         (op),
        .funct      (funct),
        .instrClass (instrClass)
    );

    controlSequencer u_sequencer (
        .clk         (clk),
        .arstN       (arstN),
        .overflow    (overflow),
        .instrClass  (instrClass),
        .state       (state),
        .step        (step),
        .instrClassQ (instrClassQ)
    );

    controlEncoder u_encoder (
        .state       (state),
        .step        (step),
        .instrClassQ (instrClassQ),
        .pcWrite     (pcWrite),
        .loadAB      (loadAB),
        .aluOutLoad  (aluOutLoad),
        .memRead     (memRead),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .wrReg       (wrReg),
        .wdReg       (wdReg),
        .aluOp       (aluOp)
    );

endmodule

`default_nettype wire

// ==== verif/tbClock.sv ====
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int PeriodNs = 4
) (
    output logic clk
);
    initial clk = 1'b0;
    always #(PeriodNs / 2) clk = ~clk;
endmodule

`default_nettype wire

// ==== verif/controlUnit_props.sv ====
// Control unit assertions
`timescale 1ns/1ps
`default_nettype none

module controlUnitProps (
    input logic              clk,
    input logic              arstN,
    input logic              overflow,
    input logic [5:0]        op,
    input logic [5:0]        funct,
    input logic              pcWrite,
    input logic              loadAB,
    input logic              aluOutLoad,
    input logic              memRead,
    input logic              irWrite,
    input logic              regWrite,
    input logic [1:0]        aluSrcA,
    input logic [1:0]        aluSrcB,
    input logic [1:0]        wrReg,
    input logic [2:0]        wdReg,
    input controlPkg::aluOpT aluOp
);
    import controlPkg::*;

    int   failCount = 0;
    logic isSub;
    logic isAddi;
    logic isAlu;

    // op and funct hold from t+1 until the next fetch
    assign isSub  = (op == opRType) && (funct == functSub);
    assign isAddi = (op == opAddi);
    assign isAlu  = isSub || isAddi || ((op == opRType) && (funct == functAdd));

    aResetInit: assert property (@(posedge clk) $rose(arstN) |->
        regWrite && wrReg == wrRegStack && wdReg == wdStackInit
        && !(pcWrite || loadAB || aluOutLoad || memRead || irWrite))
    else begin
        failCount++;
        $error("FAILED %0t reset regWrite got %b, wrReg exp %b got %b, wdReg exp %b got %b",
               $time, regWrite, wrRegStack, wrReg, wdStackInit, wdReg);
    end

    aFetch: assert property (@(posedge clk) disable iff (!arstN)
        irWrite |-> pcWrite && !memRead && $past(memRead, 1) && $past(memRead, 2)
        && $past(memRead, 3) && !$past(memRead, 4))
    else begin
        failCount++;
        $error("FAILED %0t pcWrite exp 1 got %b, or memRead run before irWrite not 3",
               $time, pcWrite);
    end

    aDecode: assert property (@(posedge clk) disable iff (!arstN)
        irWrite |=> (aluOutLoad && aluSrcB == srcBBranch) ##1 loadAB)
    else begin
        failCount++;
        $error("FAILED %0t decode aluOutLoad got %b, loadAB exp 1 got %b",
               $time, aluOutLoad, loadAB);
    end

    aCompute: assert property (@(posedge clk) disable iff (!arstN)
        irWrite ##2 isAlu |=> aluOutLoad && aluSrcA == srcARegA
        && aluSrcB == (isAddi ? srcBImm : srcBRegB)
        && aluOp == (isSub ? aluSub : aluAdd))
    else begin
        failCount++;
        $error("FAILED %0t aluOp exp %s got %s, aluSrcB exp %b got %b, aluOutLoad got %b",
               $time, isSub ? "aluSub" : "aluAdd", aluOp.name(),
               isAddi ? srcBImm : srcBRegB, aluSrcB, aluOutLoad);
    end

    aWrite: assert property (@(posedge clk) disable iff (!arstN)
        irWrite ##2 isAlu ##1 !overflow |=>
        (regWrite && !memRead && wrReg == (isAddi ? wrRegRt : wrRegRd)
        && wdReg == wdAluOut) ##1 memRead)
    else begin
        failCount++;
        $error("FAILED %0t regWrite exp 1 got %b, wrReg exp %b got %b, wdReg got %b",
               $time, regWrite, isAddi ? wrRegRt : wrRegRd, wrReg, wdReg);
    end

    aOverflow: assert property (@(posedge clk) disable iff (!arstN)
        irWrite ##2 isAlu ##1 overflow |=> (!regWrite && !memRead) ##1 memRead)
    else begin
        failCount++;
        $error("FAILED %0t overflow cycle regWrite exp 0 got %b, memRead got %b",
               $time, regWrite, memRead);
    end

    aIdle: assert property (@(posedge clk) disable iff (!arstN)
        irWrite ##2 !isAlu |=> (!aluOutLoad && !regWrite && !memRead) ##1 memRead)
    else begin
        failCount++;
        $error("FAILED %0t idle cycle regWrite exp 0 got %b, memRead got %b",
               $time, regWrite, memRead);
    end

    aExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(pcWrite && regWrite))
    else begin
        failCount++;
        $error("FAILED %0t pcWrite and regWrite both high", $time);
    end

endmodule

`default_nettype wire

// ==== verif/controlUnitTb.sv ====
// Control unit testbench
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
    import controlPkg::*;

    localparam int ClkPeriodNs  = 4;
    localparam int ResetCycles  = 5;
    localparam int InstrPerTest = 40;
    localparam int NumTests     = 3;
    // Ten cycles bound any one instruction
    localparam int WatchdogNs =
        NumTests * (InstrPerTest * 10 + ResetCycles + 20) * ClkPeriodNs + 100;

    logic       clk;
    logic       arstN;
    logic       overflow;
    logic [5:0] op;
    logic [5:0] funct;
    logic       pcWrite;
    logic       loadAB;
    logic       aluOutLoad;
    logic       memRead;
    logic       irWrite;
    logic       regWrite;
    logic [1:0] aluSrcA;
    logic [1:0] aluSrcB;
    logic [1:0] wrReg;
    logic [2:0] wdReg;
    aluOpT      aluOp;

    tbClock #(.PeriodNs(ClkPeriodNs)) u_clock (.clk(clk));

    controlUnit u_dut (.*);

    bind controlUnit controlUnitProps u_props (.*);

    // Modes 0 and 1 pick ALU instructions only
    task automatic pickInstr(input int mode, output logic [5:0] opPick,
                             output logic [5:0] functPick);
        int choice;
        choice    = (mode < 2) ? int'($urandom % 3) : int'($urandom % 8);
        opPick    = opRType;
        functPick = 6'($urandom);
        case (choice)
            0: functPick = functAdd;
            1: functPick = functSub;
            2: opPick = opAddi;
            3: opPick = opLw;
            4: opPick = opBeq;
            5: functPick = functAnd;
            // Opcode outside the instruction set
            6: opPick = 6'h3f;
            default: functPick = 6'h3f;
        endcase
    endtask

    task automatic runInstr(input int mode);
        logic [5:0] opPick;
        logic [5:0] functPick;
        logic       ovf;
        @(negedge clk);
        while (!irWrite) @(negedge clk);
        pickInstr(mode, opPick, functPick);
        ovf = (mode != 0) && ($urandom % 2 == 1);
        @(posedge clk);
        op    <= opPick;
        funct <= functPick;
        // Overflow covers only the compute cycle t+3
        repeat (2) @(posedge clk);
        overflow <= ovf;
        @(posedge clk);
        overflow <= 1'b0;
    endtask

    task automatic runTest(input int mode, input string name);
        int errorsBefore;
        errorsBefore = u_dut.u_props.failCount;
        @(posedge clk);
        arstN    <= 1'b0;
        overflow <= 1'b0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        repeat (InstrPerTest) runInstr(mode);
        // Last instruction retires before the next fetch ends
        @(negedge clk);
        while (!irWrite) @(negedge clk);
        $display("test %s done: %0d instructions, %0d assertion errors", name,
                 InstrPerTest, u_dut.u_props.failCount - errorsBefore);
    endtask

    initial begin
        int seedInit;
        arstN    <= 1'b0;
        overflow <= 1'b0;
        op       <= '0;
        funct    <= '0;
        seedInit = $urandom(32'h79ef);
        runTest(0, "alu");
        runTest(1, "overflow");
        runTest(2, "mixed");
        $display("tests %0d, assertion errors %0d", NumTests, u_dut.u_props.failCount);
        if (u_dut.u_props.failCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WatchdogNs);
        $display("watchdog expired before all tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/controlPkg.sv
src/opDecoder.sv
src/controlSequencer.sv
src/controlEncoder.sv
src/controlUnit.sv
verif/tbClock.sv
verif/controlUnit_props.sv
verif/controlUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
